// ==== all.f ====
verilog/lsu_pkg.sv
verilog/lsu.sv
verilog/bank_router.sv
verilog/ram_bank.sv
verilog/resp_merge.sv
verilog/mem_subsys_top.sv
sim/tb_mem_subsys.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the memory subsystem testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_mem_subsys -Mdir obj_dir

./obj_dir/Vtb_mem_subsys | tee sim.log

if grep -q "Verification failed" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failure"

// ==== sim/tb_mem_subsys.sv ====
`timescale 1ns/100ps

module tb_mem_subsys import lsu_pkg::*; ();

  localparam int NUM_BANKS    = 4;
  localparam int BANK_WORDS   = 64;
  localparam int MEM_BYTES    = NUM_BANKS * BANK_WORDS * 8;
  localparam int AW_BITS      = $clog2(MEM_BYTES);
  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 16;
  localparam int RAND_ROUNDS  = 64;
  localparam int ROUNDS       = 4;
  // store plus two word loads for 8 bytes and 4 halves
  localparam int MERGE_OPS    = (8 + 4) * 3;
  // signed and unsigned loads at 8 byte and 4 half offsets
  localparam int EXT_OPS      = 8 * 2 + 4 * 2;
  localparam int NUM_OPS      = MEM_BYTES / 4 + 3 * RAND_ROUNDS + ROUNDS * (MERGE_OPS + EXT_OPS);

  logic                   clk;
  logic                   rstn;
  logic [ADDR_W-1:0]      raddr;
  load_func_e             rfunc;
  logic                   rreq_valid;
  logic                   rreq_ready;
  logic [CORE_DATA_W-1:0] rdata;
  logic                   rres_valid;
  logic                   rres_ready;
  logic [ADDR_W-1:0]      waddr;
  store_func_e            wfunc;
  logic [CORE_DATA_W-1:0] wdata;
  logic                   wreq_valid;
  logic                   wreq_ready;
  logic                   wres_valid;
  logic                   wres_ready;

  logic [7:0]             model [0:MEM_BYTES-1];
  logic [CORE_DATA_W-1:0] exp_q [$];
  load_func_e             func_q [$];
  int                     stores_open = 0;
  int                     value_errs = 0;
  int                     proto_errs = 0;
  logic [15:0]            lfsr = 16'd23;

  mem_subsys_top #(.NUM_BANKS(NUM_BANKS), .BANK_WORDS(BANK_WORDS)) uut (
    .clk(clk), .rstn(rstn),
    .raddr(raddr), .rfunc(rfunc), .rreq_valid(rreq_valid), .rreq_ready(rreq_ready),
    .rdata(rdata), .rres_valid(rres_valid), .rres_ready(rres_ready),
    .waddr(waddr), .wfunc(wfunc), .wdata(wdata),
    .wreq_valid(wreq_valid), .wreq_ready(wreq_ready),
    .wres_valid(wres_valid), .wres_ready(wres_ready)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [63:0] model_dword(input logic [ADDR_W-1:0] addr);
    logic [63:0] dw;
    for (int i = 0; i < 8; i++) begin
      dw[8*i +: 8] = model[{addr[ADDR_W-1:3], 3'(i)}];
    end
    return dw;
  endfunction

  // expected core rdata per RISC-V load rules
  function automatic logic [CORE_DATA_W-1:0] load_ref(input logic [63:0] dword,
                                                      input logic [ADDR_W-1:0] addr,
                                                      input load_func_e func);
    int         off;
    logic [7:0] b0;
    logic [7:0] b1;
    off = int'(addr[2:0]);
    b0  = dword[8*off +: 8];
    b1  = dword[8*((off + 1) % 8) +: 8];
    case (func)
      LD_BS:   return {{24{b0[7]}}, b0};
      LD_BU:   return {24'h0, b0};
      LD_HS:   return {{16{b1[7]}}, b1, b0};
      LD_HU:   return {16'h0, b1, b0};
      default: return dword[8*off +: 32];
    endcase
  endfunction

  task automatic check_load(input logic [CORE_DATA_W-1:0] expected,
                            input logic [CORE_DATA_W-1:0] actual, input load_func_e func);
    if (actual !== expected) begin
      value_errs++;
      $display("FAIL %0t ns rdata (%s) expected %h actual %h",
               $time, func.name(), expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      value_errs++;
      $display("FAIL %0t ns %s expected %b actual %b", $time, name, expected, actual);
    end
  endtask

  task automatic do_load(input logic [ADDR_W-1:0] addr, input load_func_e func,
                         input int stall);
    logic [CORE_DATA_W-1:0] held;
    logic                   was_low;
    @(negedge clk);
    raddr      = addr;
    rfunc      = func;
    rreq_valid = 1'b1;
    rres_ready = (stall == 0);
    exp_q.push_back(load_ref(model_dword(addr), addr, func));
    func_q.push_back(func);
    do begin
      @(posedge clk);
    end while (!rreq_ready);
    was_low = !rres_valid;
    @(negedge clk);
    rreq_valid = 1'b0;
    @(posedge clk);
    if (!was_low || !rres_valid) begin
      proto_errs++;
      $display("load response did not rise one cycle after the request at %0t ns", $time);
    end
    held = rdata;
    // response and data must hold while the core stalls
    for (int i = 0; i < stall; i++) begin
      if (!rres_valid || rdata !== held || rreq_ready) begin
        proto_errs++;
        $display("load response not held under back-pressure at %0t ns", $time);
      end
      @(negedge clk);
      rres_ready = (i == stall - 1);
      @(posedge clk);
    end
  endtask

  task automatic do_store(input logic [ADDR_W-1:0] addr, input store_func_e func,
                          input logic [CORE_DATA_W-1:0] data, input int stall);
    int   nbytes;
    int   waited;
    logic was_low;
    nbytes = (func == ST_B) ? 1 : ((func == ST_H) ? 2 : 4);
    @(negedge clk);
    waddr      = addr;
    wfunc      = func;
    wdata      = data;
    wreq_valid = 1'b1;
    wres_ready = (stall == 0);
    for (int i = 0; i < nbytes; i++) begin
      model[addr + ADDR_W'(i)] = data[8*i +: 8];
    end
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!wreq_ready);
    // aw in the first cycle and w in the second
    if (waited != 2) begin
      proto_errs++;
      $display("store taken after %0d cycles instead of 2 at %0t ns", waited, $time);
    end
    was_low = !wres_valid;
    @(negedge clk);
    wreq_valid = 1'b0;
    stores_open++;
    @(posedge clk);
    if (!was_low || !wres_valid) begin
      proto_errs++;
      $display("store response did not rise one cycle after the request at %0t ns", $time);
    end
    for (int i = 0; i < stall; i++) begin
      if (!wres_valid || wreq_ready) begin
        proto_errs++;
        $display("store response not held under back-pressure at %0t ns", $time);
      end
      @(negedge clk);
      wres_ready = (i == stall - 1);
      @(posedge clk);
    end
  endtask

  // partial store followed by both words of the double word
  task automatic store_then_verify(input logic [ADDR_W-1:0] addr, input store_func_e func);
    logic [ADDR_W-1:0] base;
    base = {addr[ADDR_W-1:3], 3'b000};
    do_store(addr, func, rand_bits(32), 0);
    do_load(base, LD_W, 0);
    do_load(base + 4, LD_W, 0);
  endtask

  // response checker
  always @(posedge clk) begin
    if (rstn && rres_valid && rres_ready) begin
      if (exp_q.size() == 0) begin
        proto_errs++;
        $display("load response at %0t ns with no load outstanding", $time);
      end else begin
        check_load(exp_q.pop_front(), rdata, func_q.pop_front());
      end
    end
    if (rstn && wres_valid && wres_ready) begin
      if (stores_open == 0) begin
        proto_errs++;
        $display("store response at %0t ns with no store outstanding", $time);
      end else begin
        stores_open--;
      end
    end
  end

  initial begin
    logic [ADDR_W-1:0] addr;
    logic [ADDR_W-1:0] base;
    rstn       = 1'b0;
    raddr      = '0;
    rfunc      = LD_W;
    rreq_valid = 1'b0;
    rres_ready = 1'b1;
    waddr      = '0;
    wfunc      = ST_W;
    wdata      = '0;
    wreq_valid = 1'b0;
    wres_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    @(posedge clk);
    check_flag("rres_valid", 1'b0, rres_valid);
    check_flag("wres_valid", 1'b0, wres_valid);
    check_flag("rreq_ready", 1'b1, rreq_ready);

    // known contents in every word
    for (int a = 0; a < MEM_BYTES; a += 4) begin
      do_store(ADDR_W'(a), ST_W, rand_bits(32), 0);
    end

    // random words over all banks with stalls
    for (int n = 0; n < RAND_ROUNDS; n++) begin
      addr = rand_bits(AW_BITS - 2) << 2;
      do_store(addr, ST_W, rand_bits(32), int'(rand_bits(3)));
      do_load(addr, LD_W, int'(rand_bits(3)));
      do_load(rand_bits(AW_BITS - 2) << 2, LD_W, int'(rand_bits(3)));
    end

    for (int r = 0; r < ROUNDS; r++) begin
      base = rand_bits(AW_BITS - 3) << 3;
      for (int off = 0; off < 8; off++) begin
        store_then_verify(base + ADDR_W'(off), ST_B);
      end
      for (int off = 0; off < 8; off += 2) begin
        store_then_verify(base + ADDR_W'(off), ST_H);
      end
      // sign and zero extension at each offset
      for (int off = 0; off < 8; off++) begin
        do_load(base + ADDR_W'(off), LD_BS, 0);
        do_load(base + ADDR_W'(off), LD_BU, 0);
        if (off % 2 == 0) begin
          do_load(base + ADDR_W'(off), LD_HS, 0);
          do_load(base + ADDR_W'(off), LD_HU, 0);
        end
      end
    end

    @(negedge clk);
    // every issued request must have seen its response
    if (exp_q.size() != 0 || stores_open != 0) begin
      proto_errs++;
      $display("%0d load and %0d store responses never arrived", exp_q.size(), stores_open);
    end
    $display("errors: value %0d, protocol %0d", value_errs, proto_errs);
    if (value_errs + proto_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // watchdog allows 20 cycles per operation
  initial begin
    #((RESET_CYCLES + 20 * NUM_OPS) * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", RESET_CYCLES + 20 * NUM_OPS);
    $display("errors: value %0d, protocol %0d", value_errs, proto_errs);
    $display("Verification failed");
    $finish;
  end

endmodule

// ==== verilog/bank_router.sv ====
`timescale 1ns/100ps

module bank_router import lsu_pkg::*; #(
  parameter  int NUM_BANKS  = 4,
  parameter  int BANK_WORDS = 64,
  localparam int SEL_W      = $clog2(NUM_BANKS),
  localparam int IDX_W      = $clog2(BANK_WORDS)
) (
  input  logic                                  clk,
  input  logic                                  rstn,
  input  logic                                  arvalid,
  input  logic [ADDR_W-1:0]                     araddr,
  output logic                                  arready,
  input  logic                                  awvalid,
  input  logic [ADDR_W-1:0]                     awaddr,
  output logic                                  awready,
  input  logic                                  wvalid,
  input  logic [BUS_DATA_W-1:0]                 wdata,
  input  logic [BUS_STRB_W-1:0]                 wstrb,
  output logic                                  wready,
  input  logic                                  r_done,
  input  logic                                  b_done,
  output logic [NUM_BANKS-1:0]                  bank_arvalid,
  output logic [NUM_BANKS-1:0][IDX_W-1:0]       bank_araddr,
  input  logic [NUM_BANKS-1:0]                  bank_arready,
  output logic [NUM_BANKS-1:0]                  bank_awvalid,
  output logic [NUM_BANKS-1:0][IDX_W-1:0]       bank_awaddr,
  input  logic [NUM_BANKS-1:0]                  bank_awready,
  output logic [NUM_BANKS-1:0]                  bank_wvalid,
  output logic [NUM_BANKS-1:0][BUS_DATA_W-1:0]  bank_wdata,
  output logic [NUM_BANKS-1:0][BUS_STRB_W-1:0]  bank_wstrb,
  input  logic [NUM_BANKS-1:0]                  bank_wready
);

  typedef enum logic {RD_IDLE, RD_BUSY} rd_state_e;
  typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_e;

  rd_state_e        rd_state;
  wr_state_e        wr_state;
  logic [SEL_W-1:0] ar_sel;
  logic [SEL_W-1:0] aw_sel;
  logic [SEL_W-1:0] wr_bank;

  // double word interleave, bank bits sit right above the byte offset
  assign ar_sel = araddr[3 +: SEL_W];
  assign aw_sel = awaddr[3 +: SEL_W];

  // payload goes to every bank, only the valid is steered
  assign bank_araddr = {NUM_BANKS{araddr[3+SEL_W +: IDX_W]}};
  assign bank_awaddr = {NUM_BANKS{awaddr[3+SEL_W +: IDX_W]}};
  assign bank_wdata  = {NUM_BANKS{wdata}};
  assign bank_wstrb  = {NUM_BANKS{wstrb}};

  always_comb begin
    bank_arvalid = '0;
    bank_awvalid = '0;
    bank_wvalid  = '0;
    if (rd_state == RD_IDLE) begin
      bank_arvalid[ar_sel] = arvalid;
    end
    if (wr_state == WR_IDLE) begin
      bank_awvalid[aw_sel] = awvalid;
    end
    if (wr_state == WR_DATA) begin
      bank_wvalid[wr_bank] = wvalid;
    end
  end

  assign arready = (rd_state == RD_IDLE) && bank_arready[ar_sel];
  assign awready = (wr_state == WR_IDLE) && bank_awready[aw_sel];
  assign wready  = (wr_state == WR_DATA) && bank_wready[wr_bank];

  // one read in flight until the core takes the response
  always_ff @(posedge clk) begin
    if (!rstn) begin
      rd_state <= RD_IDLE;
    end else if (rd_state == RD_IDLE) begin
      if (arvalid && arready) begin
        rd_state <= RD_BUSY;
      end
    end else if (r_done) begin
      rd_state <= RD_IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_state <= WR_IDLE;
    end else begin
      case (wr_state)
        WR_IDLE: if (awvalid && awready) wr_state <= WR_DATA;
        WR_DATA: if (wvalid && wready) wr_state <= WR_RESP;
        default: if (b_done) wr_state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (awvalid && awready) begin
      wr_bank <= aw_sel;
    end
  end

endmodule

// ==== verilog/lsu.sv ====
`timescale 1ns/100ps

module lsu import lsu_pkg::*; (
  input  logic                   clk,
  input  logic                   rstn,
  // core load request and response
  input  logic [ADDR_W-1:0]      raddr,
  input  load_func_e             rfunc,
  input  logic                   rreq_valid,
  output logic                   rreq_ready,
  output logic [CORE_DATA_W-1:0] rdata,
  output logic                   rres_valid,
  input  logic                   rres_ready,
  // core store request and response
  input  store_func_e            wfunc,
  input  logic [ADDR_W-1:0]      waddr,
  input  logic [CORE_DATA_W-1:0] wdata,
  input  logic                   wreq_valid,
  output logic                   wreq_ready,
  output logic                   wres_valid,
  input  logic                   wres_ready,
  // bus read channels
  output logic                   arvalid,
  output logic [ADDR_W-1:0]      araddr,
  input  logic                   arready,
  input  logic                   rvalid,
  input  logic [BUS_DATA_W-1:0]  bus_rdata,
  output logic                   rready,
  // bus write channels
  output logic                   awvalid,
  output logic [ADDR_W-1:0]      awaddr,
  output logic                   wvalid,
  output logic [BUS_DATA_W-1:0]  bus_wdata,
  output logic [BUS_STRB_W-1:0]  wstrb,
  input  logic                   awready,
  input  logic                   wready,
  input  logic                   bvalid,
  output logic                   bready
);

  logic [2:0]            rshift_q;
  load_func_e            rfunc_q;
  logic [BUS_DATA_W-1:0] rdata_shifted;
  logic [BUS_STRB_W-1:0] base_mask;
  logic                  aw_open;
  logic                  w_open;

  // load path
  assign arvalid    = rreq_valid;
  assign araddr     = raddr;
  assign rreq_ready = arready;

  // byte offset and function kept for the response
  always_ff @(posedge clk) begin
    if (arvalid && arready) begin
      rshift_q <= raddr[2:0];
      rfunc_q  <= rfunc;
    end
  end

  assign rdata_shifted = bus_rdata >> {rshift_q, 3'b000};

  always_comb begin
    case (rfunc_q)
      LD_BS: rdata = {{(CORE_DATA_W-8){rdata_shifted[7]}}, rdata_shifted[7:0]};
      LD_BU: rdata = {{(CORE_DATA_W-8){1'b0}}, rdata_shifted[7:0]};
      LD_HS: rdata = {{(CORE_DATA_W-16){rdata_shifted[15]}}, rdata_shifted[15:0]};
      LD_HU: rdata = {{(CORE_DATA_W-16){1'b0}}, rdata_shifted[15:0]};
      default: rdata = rdata_shifted[CORE_DATA_W-1:0];
    endcase
  end

  assign rres_valid = rvalid;
  assign rready     = rres_ready;

  // store path, data and strobes moved to the byte lane
  always_comb begin
    case (wfunc)
      ST_B: base_mask = BUS_STRB_W'(1);
      ST_H: base_mask = BUS_STRB_W'(3);
      default: base_mask = BUS_STRB_W'(15);
    endcase
  end

  assign wstrb     = base_mask << waddr[2:0];
  assign bus_wdata = BUS_DATA_W'(wdata) << {waddr[2:0], 3'b000};
  assign awaddr    = waddr;

  // high while aw or w of the current store is still to be sent
  always_ff @(posedge clk) begin
    if (!rstn || (bvalid && bready)) begin
      aw_open <= 1'b1;
      w_open  <= 1'b1;
    end else begin
      if (awvalid && awready) begin
        aw_open <= 1'b0;
      end
      if (wvalid && wready) begin
        w_open <= 1'b0;
      end
    end
  end

  assign awvalid = wreq_valid & aw_open;
  assign wvalid  = wreq_valid & w_open;

  // request taken with the w beat, once aw is through
  assign wreq_ready = w_open & wready & (awready | ~aw_open);

  assign wres_valid = bvalid;
  assign bready     = wres_ready;

endmodule

// ==== verilog/lsu_pkg.sv ====
package lsu_pkg;

  // core side data width
  parameter int CORE_DATA_W = 32;

  // memory bus widths
  parameter int BUS_DATA_W = 64;
  parameter int BUS_STRB_W = BUS_DATA_W / 8;
  parameter int ADDR_W = 32;

  // load function, funct3 encoding
  typedef enum logic [2:0] {
    LD_BS = 3'd0,
    LD_HS = 3'd1,
    LD_W  = 3'd2,
    LD_BU = 3'd4,
    LD_HU = 3'd5
  } load_func_e;

  // store function, funct3 encoding
  typedef enum logic [2:0] {
    ST_B = 3'd0,
    ST_H = 3'd1,
    ST_W = 3'd2
  } store_func_e;

endpackage

// ==== verilog/mem_subsys_top.sv ====
`timescale 1ns/100ps

module mem_subsys_top import lsu_pkg::*; #(
  parameter int NUM_BANKS  = 4,
  parameter int BANK_WORDS = 64
) (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic [ADDR_W-1:0]      raddr,
  input  load_func_e             rfunc,
  input  logic                   rreq_valid,
  output logic                   rreq_ready,
  output logic [CORE_DATA_W-1:0] rdata,
  output logic                   rres_valid,
  input  logic                   rres_ready,
  input  logic [ADDR_W-1:0]      waddr,
  input  store_func_e            wfunc,
  input  logic [CORE_DATA_W-1:0] wdata,
  input  logic                   wreq_valid,
  output logic                   wreq_ready,
  output logic                   wres_valid,
  input  logic                   wres_ready
);

  localparam int IDX_W = $clog2(BANK_WORDS);

  // lsu side bus
  logic                  arvalid, arready, rvalid, rready;
  logic                  awvalid, awready, wvalid, wready, bvalid, bready;
  logic [ADDR_W-1:0]     araddr, awaddr;
  logic [BUS_DATA_W-1:0] bus_rdata, bus_wdata;
  logic [BUS_STRB_W-1:0] wstrb;
  logic                  r_done, b_done;

  // per bank
  logic [NUM_BANKS-1:0]                 bank_arvalid, bank_arready;
  logic [NUM_BANKS-1:0]                 bank_awvalid, bank_awready;
  logic [NUM_BANKS-1:0]                 bank_wvalid, bank_wready;
  logic [NUM_BANKS-1:0][IDX_W-1:0]      bank_araddr, bank_awaddr;
  logic [NUM_BANKS-1:0][BUS_DATA_W-1:0] bank_wdata, bank_rdata;
  logic [NUM_BANKS-1:0][BUS_STRB_W-1:0] bank_wstrb;
  logic [NUM_BANKS-1:0]                 bank_rvalid, bank_rready;
  logic [NUM_BANKS-1:0]                 bank_bvalid, bank_bready;

  // transaction ends when the core takes the response
  assign r_done = rvalid & rready;
  assign b_done = bvalid & bready;

  lsu u_lsu (
    .clk(clk), .rstn(rstn),
    .raddr(raddr), .rfunc(rfunc), .rreq_valid(rreq_valid), .rreq_ready(rreq_ready),
    .rdata(rdata), .rres_valid(rres_valid), .rres_ready(rres_ready),
    .wfunc(wfunc), .waddr(waddr), .wdata(wdata),
    .wreq_valid(wreq_valid), .wreq_ready(wreq_ready),
    .wres_valid(wres_valid), .wres_ready(wres_ready),
    .arvalid(arvalid), .araddr(araddr), .arready(arready),
    .rvalid(rvalid), .bus_rdata(bus_rdata), .rready(rready),
    .awvalid(awvalid), .awaddr(awaddr), .wvalid(wvalid),
    .bus_wdata(bus_wdata), .wstrb(wstrb),
    .awready(awready), .wready(wready), .bvalid(bvalid), .bready(bready)
  );

  bank_router #(.NUM_BANKS(NUM_BANKS), .BANK_WORDS(BANK_WORDS)) u_router (
    .clk(clk), .rstn(rstn),
    .arvalid(arvalid), .araddr(araddr), .arready(arready),
    .awvalid(awvalid), .awaddr(awaddr), .awready(awready),
    .wvalid(wvalid), .wdata(bus_wdata), .wstrb(wstrb), .wready(wready),
    .r_done(r_done), .b_done(b_done),
    .bank_arvalid(bank_arvalid), .bank_araddr(bank_araddr), .bank_arready(bank_arready),
    .bank_awvalid(bank_awvalid), .bank_awaddr(bank_awaddr), .bank_awready(bank_awready),
    .bank_wvalid(bank_wvalid), .bank_wdata(bank_wdata), .bank_wstrb(bank_wstrb),
    .bank_wready(bank_wready)
  );

  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    ram_bank #(.BANK_WORDS(BANK_WORDS)) u_bank (
      .clk(clk), .rstn(rstn),
      .arvalid(bank_arvalid[i]), .arindex(bank_araddr[i]), .arready(bank_arready[i]),
      .rvalid(bank_rvalid[i]), .rdata(bank_rdata[i]), .rready(bank_rready[i]),
      .awvalid(bank_awvalid[i]), .awindex(bank_awaddr[i]), .awready(bank_awready[i]),
      .wvalid(bank_wvalid[i]), .wdata(bank_wdata[i]), .wstrb(bank_wstrb[i]),
      .wready(bank_wready[i]),
      .bvalid(bank_bvalid[i]), .bready(bank_bready[i])
    );
  end

  resp_merge #(.NUM_BANKS(NUM_BANKS)) u_merge (
    .bank_rvalid(bank_rvalid), .bank_rdata(bank_rdata), .bank_bvalid(bank_bvalid),
    .bank_rready(bank_rready), .bank_bready(bank_bready),
    .rvalid(rvalid), .rdata(bus_rdata), .bvalid(bvalid),
    .rready(rready), .bready(bready)
  );

endmodule

// ==== verilog/ram_bank.sv ====
`timescale 1ns/100ps

module ram_bank import lsu_pkg::*; #(
  parameter  int BANK_WORDS = 64,
  localparam int IDX_W      = $clog2(BANK_WORDS)
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  arvalid,
  input  logic [IDX_W-1:0]      arindex,
  output logic                  arready,
  output logic                  rvalid,
  output logic [BUS_DATA_W-1:0] rdata,
  input  logic                  rready,
  input  logic                  awvalid,
  input  logic [IDX_W-1:0]      awindex,
  output logic                  awready,
  input  logic                  wvalid,
  input  logic [BUS_DATA_W-1:0] wdata,
  input  logic [BUS_STRB_W-1:0] wstrb,
  output logic                  wready,
  output logic                  bvalid,
  input  logic                  bready
);

  typedef enum logic [1:0] {BK_IDLE, BK_ADDR, BK_RESP} bk_state_e;

  bk_state_e             state;
  logic [IDX_W-1:0]      wr_index;
  logic [BUS_DATA_W-1:0] mem [0:BANK_WORDS-1];

  // read side, no new address while data waits
  assign arready = ~rvalid;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rvalid <= 1'b0;
    end else if (arvalid && arready) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (arvalid && arready) begin
      rdata <= mem[arindex];
    end
  end

  // write side
  assign awready = (state == BK_IDLE);
  assign wready  = (state == BK_ADDR);
  assign bvalid  = (state == BK_RESP);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= BK_IDLE;
    end else begin
      case (state)
        BK_IDLE: if (awvalid && awready) state <= BK_ADDR;
        BK_ADDR: if (wvalid && wready) state <= BK_RESP;
        default: if (bready) state <= BK_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (awvalid && awready) begin
      wr_index <= awindex;
    end
    if (wvalid && wready) begin
      // strobed bytes only
      for (int i = 0; i < BUS_STRB_W; i++) begin
        if (wstrb[i]) begin
          mem[wr_index][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
  end

endmodule

// ==== verilog/resp_merge.sv ====
`timescale 1ns/100ps

module resp_merge import lsu_pkg::*; #(
  parameter int NUM_BANKS = 4
) (
  input  logic [NUM_BANKS-1:0]                 bank_rvalid,
  input  logic [NUM_BANKS-1:0][BUS_DATA_W-1:0] bank_rdata,
  input  logic [NUM_BANKS-1:0]                 bank_bvalid,
  output logic [NUM_BANKS-1:0]                 bank_rready,
  output logic [NUM_BANKS-1:0]                 bank_bready,
  output logic                                 rvalid,
  output logic [BUS_DATA_W-1:0]                rdata,
  output logic                                 bvalid,
  input  logic                                 rready,
  input  logic                                 bready
);

  // at most one bank answers per channel
  assign rvalid = |bank_rvalid;
  assign bvalid = |bank_bvalid;

  assign bank_rready = bank_rvalid & {NUM_BANKS{rready}};
  assign bank_bready = bank_bvalid & {NUM_BANKS{bready}};

  // one-hot and-or mux
  always_comb begin
    rdata = '0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      if (bank_rvalid[i]) begin
        rdata = rdata | bank_rdata[i];
      end
    end
  end

endmodule
